/* compile.f */
source/obj_pkg.sv
source/obj_cfg_regs.sv
source/obj_frame_table.sv
source/obj_tile_match.sv
source/obj_line_scan.sv
source/obj_draw_queue.sv
source/obj_scan_top.sv
verif/obj_scan_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sprite scanner testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module obj_scan_tb -o obj_scan_sim

out=$(./obj_dir/obj_scan_sim)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

/* source/obj_cfg_regs.sv */
/*
  Sprite position offset registers on the cpu write port.
  Only address bits 10 and 2..0 are decoded, so the registers alias across bits 9..3.
  Each enabled byte lane is stored after the bias is taken off the merged word.
*/
`timescale 1ns/1ps

module obj_cfg_regs
    import obj_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_cs,
    input  logic [CPU_AW-1:0] cpu_addr,
    input  logic [15:0]       cpu_dout,
    input  logic [1:0]        cpu_dsn,   // active low byte strobes
    output logic [XPOS_W-1:0] off_x,
    output logic [VPOS_W-1:0] off_y
);

    logic              reg_wr;
    logic [XPOS_W-1:0] merged_x;
    logic [VPOS_W-1:0] merged_y;
    logic [XPOS_W-1:0] next_x;
    logic [VPOS_W-1:0] next_y;

    assign reg_wr = cpu_cs && cpu_addr[CPU_AW-1];

    // lanes that are not strobed keep the stored value
    always_comb begin
        merged_x = off_x;
        merged_y = off_y;
        if (!cpu_dsn[0]) begin
            merged_x[7:0] = cpu_dout[7:0];
            merged_y[7:0] = cpu_dout[7:0];
        end
        if (!cpu_dsn[1]) begin
            merged_x[9:8] = cpu_dout[9:8];
            merged_y[8]   = cpu_dout[8];
        end
    end

    assign next_x = merged_x - XOFF_BIAS;
    assign next_y = merged_y - YOFF_BIAS;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            off_x <= '0;
            off_y <= '0;
        end else if (reg_wr) begin
            if (cpu_addr[2:0] == REG_XOFF) begin
                if (!cpu_dsn[0]) off_x[7:0] <= next_x[7:0];
                if (!cpu_dsn[1]) off_x[9:8] <= next_x[9:8];   // carry from low lane lands here
            end
            if (cpu_addr[2:0] == REG_YOFF) begin
                if (!cpu_dsn[0]) off_y[7:0] <= next_y[7:0];
                if (!cpu_dsn[1]) off_y[8]   <= next_y[8];
            end
        end
    end

endmodule

/* source/obj_draw_queue.sv */
/*
  Draw command FIFO between scanner and renderer.
  Pushes while full are ignored, the scanner never issues them.
  dr_cmd is stable while dr_valid waits for dr_ready.
*/
`timescale 1ns/1ps

module obj_draw_queue
    import obj_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              q_push,
    input  logic [DRAW_W-1:0] q_cmd,
    input  logic              dr_ready,
    output logic              q_full,
    output logic              dr_valid,
    output logic [DRAW_W-1:0] dr_cmd
);

    logic [DRAW_W-1:0]   mem [QUEUE_DEPTH];
    logic [QUEUE_AW-1:0] wr_ptr;
    logic [QUEUE_AW-1:0] rd_ptr;
    logic [QUEUE_AW:0]   count;
    logic                do_push;
    logic                do_pop;

    assign q_full   = (count == QUEUE_DEPTH[QUEUE_AW:0]);
    assign dr_valid = (count != '0);
    assign dr_cmd   = mem[rd_ptr];

    assign do_push = q_push && !q_full;
    assign do_pop  = dr_valid && dr_ready;

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= q_cmd;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/obj_frame_table.sv */
/*
  Sprite entry memory, one RAM per field.
  Contents are undefined after power up; the cpu must write every entry the scan can reach.
  Read data appears one cycle after table_addr.
*/
`timescale 1ns/1ps

module obj_frame_table
    import obj_pkg::*;
(
    input  logic                clk,
    input  logic                cpu_cs,
    input  logic [CPU_AW-1:0]   cpu_addr,
    input  logic [15:0]         cpu_dout,
    input  logic [1:0]          cpu_dsn,
    input  logic [TABLE_AW-1:0] table_addr,
    output logic [15:0]         table_x,
    output logic [15:0]         table_y,
    output logic [15:0]         table_code,
    output logic [15:0]         table_attr
);

    logic                tbl_wr;
    logic [TABLE_AW-1:0] wr_idx;
    logic [1:0]          wr_fld;

    assign tbl_wr = cpu_cs && !cpu_addr[CPU_AW-1];
    assign wr_idx = cpu_addr[TABLE_AW+1:2];
    assign wr_fld = cpu_addr[1:0];

    for (genvar f = 0; f < 4; f++) begin : g_field
        logic [15:0] mem [TABLE_DEPTH];
        logic [15:0] rd_q;

        always_ff @(posedge clk) begin
            if (tbl_wr && wr_fld == 2'(f)) begin
                if (!cpu_dsn[0]) mem[wr_idx][7:0]  <= cpu_dout[7:0];
                if (!cpu_dsn[1]) mem[wr_idx][15:8] <= cpu_dout[15:8];
            end
            rd_q <= mem[table_addr];   // whole entry read in one go
        end
    end

    assign table_x    = g_field[FLD_X].rd_q;
    assign table_y    = g_field[FLD_Y].rd_q;
    assign table_code = g_field[FLD_CODE].rd_q;
    assign table_attr = g_field[FLD_ATTR].rd_q;

endmodule

/* source/obj_line_scan.sv */
/*
  Per line sprite sequencer.
  A rising edge on start (re)starts the walk at entry 0, even mid line.
  One table entry is processed at a time; the table address holds until the entry is finished,
  so table fields stay valid through the column loop. line_done pulses once per finished line.
*/
`timescale 1ns/1ps

module obj_line_scan
    import obj_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                flip,
    input  logic [VPOS_W-1:0]   vrender,
    input  logic                start,
    input  logic [XPOS_W-1:0]   off_x,
    input  logic [15:0]         table_x,
    input  logic [15:0]         table_y,   // end marker in bit 15
    input  logic [15:0]         table_attr,
    input  logic                inzone,
    input  logic [3:0]          vsub,
    input  logic [15:0]         code_mn,
    input  logic                q_full,
    output logic [TABLE_AW-1:0] table_addr,
    output logic                match_en,
    output logic [VPOS_W-1:0]   vrenderf,
    output logic [3:0]          n,
    output logic                q_push,
    output logic [DRAW_W-1:0]   q_cmd,
    output logic                line_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,    // address out, waiting for read data
        ST_CHECK,    // entry valid, end marker test
        ST_MATCH,    // zone result valid
        ST_COLUMN
    } scan_state_t;

    scan_state_t       st;
    logic              last_start;
    logic              start_edge;
    logic [3:0]        tile_n;
    logic              hflip;
    logic              end_mark;
    logic [3:0]        npos;
    logic [XPOS_W-1:0] eff_x;
    logic              col_vis;
    logic              col_step;
    logic              last_col;
    logic              next_entry;

    assign start_edge = start && !last_start;

    assign tile_n   = table_attr[11:8];
    assign hflip    = table_attr[5];
    assign end_mark = table_y[15] || (table_attr[15:8] == 8'hff);

    // horizontal tile slot, walked backwards under hflip
    assign npos  = hflip ? tile_n - n : n;
    assign eff_x = table_x[XPOS_W-1:0] - off_x + {2'b00, npos, 4'h0};
    assign col_vis = !eff_x[XPOS_W-1];

    // an off screen column steps without a push, a visible one waits for room
    assign col_step = (st == ST_COLUMN) && (!col_vis || !q_full);
    assign last_col = (n == tile_n);

    assign next_entry = ((st == ST_MATCH) && !inzone) || (col_step && last_col);

    assign match_en = (st == ST_CHECK) && !end_mark;
    assign q_push   = (st == ST_COLUMN) && col_vis && !q_full;
    assign q_cmd    = {code_mn,
                       4'h0, vsub, table_attr[7:0],
                       eff_x[HPOS_W-1:0],
                       table_x[15:13]};   // prio

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            st         <= ST_IDLE;
            last_start <= 1'b0;
            table_addr <= '0;
            n          <= '0;
            line_done  <= 1'b0;
        end else begin
            last_start <= start;
            line_done  <= 1'b0;
            case (st)
                ST_FETCH: st <= ST_CHECK;
                ST_CHECK: begin
                    if (end_mark) begin
                        st        <= ST_IDLE;
                        line_done <= 1'b1;
                    end else begin
                        n  <= '0;
                        st <= ST_MATCH;
                    end
                end
                ST_MATCH: begin
                    if (inzone) st <= ST_COLUMN;
                end
                ST_COLUMN: begin
                    if (col_step && !last_col) n <= n + 4'd1;
                end
                default: st <= ST_IDLE;
            endcase

            if (next_entry) begin
                if (&table_addr) begin   // entry 255 was the last one
                    st        <= ST_IDLE;
                    line_done <= 1'b1;
                end else begin
                    table_addr <= table_addr + 1'b1;
                    st         <= ST_FETCH;
                end
            end

            // a new line overrides whatever was going on
            if (start_edge) begin
                table_addr <= '0;
                st         <= ST_FETCH;
            end
        end
    end

    // line number seen by the zone test
    always_ff @(posedge clk) begin
        if (start_edge) vrenderf <= vrender ^ {1'b0, {8{flip}}};
    end

endmodule

/* source/obj_pkg.sv */
/*
  Shared constants for the sprite line scanner.
  Table is 256 entries of four 16-bit fields, written by the CPU one field at a time.
  Offsets are stored with the bias already removed.
*/
package obj_pkg;

    // frame table geometry
    localparam int TABLE_DEPTH = 256;
    localparam int TABLE_AW    = 8;

    // field index inside an entry, taken from cpu address bits 1..0
    localparam logic [1:0] FLD_X    = 2'd0;
    localparam logic [1:0] FLD_Y    = 2'd1;
    localparam logic [1:0] FLD_CODE = 2'd2;
    localparam logic [1:0] FLD_ATTR = 2'd3;

    // cpu word address, bit 10 picks table or registers
    localparam int CPU_AW = 11;

    localparam logic [2:0] REG_XOFF = 3'd4;
    localparam logic [2:0] REG_YOFF = 3'd5;

    // screen coordinates
    localparam int HPOS_W = 9;
    localparam int VPOS_W = 9;
    localparam int XPOS_W = 10;   // sprite x and horizontal offset

    // subtracted from whatever the cpu writes
    localparam logic [XPOS_W-1:0] XOFF_BIAS = 10'h040;
    localparam logic [VPOS_W-1:0] YOFF_BIAS = 9'h010;

    // draw command: code, attr, hpos, prio from the top down
    localparam int DRAW_W = 16 + 16 + HPOS_W + 3;

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_AW    = 2;

endpackage

/* source/obj_scan_top.sv */
/*
  Sprite line scanner top level.
  Table, offsets and line number come in, draw commands go out on a valid/ready port.
*/
`timescale 1ns/1ps

module obj_scan_top
    import obj_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              flip,
    input  logic [VPOS_W-1:0] vrender,
    input  logic              start,
    input  logic              cpu_cs,
    input  logic [CPU_AW-1:0] cpu_addr,
    input  logic [15:0]       cpu_dout,
    input  logic [1:0]        cpu_dsn,
    output logic              dr_valid,
    output logic [DRAW_W-1:0] dr_cmd,
    input  logic              dr_ready,
    output logic              line_done
);

    logic [XPOS_W-1:0]   off_x;
    logic [VPOS_W-1:0]   off_y;
    logic [TABLE_AW-1:0] table_addr;
    logic [15:0]         table_x;
    logic [15:0]         table_y;
    logic [15:0]         table_code;
    logic [15:0]         table_attr;
    logic                match_en;
    logic [VPOS_W-1:0]   vrenderf;
    logic [3:0]          n;
    logic                inzone;
    logic [3:0]          vsub;
    logic [15:0]         code_mn;
    logic                q_push;
    logic [DRAW_W-1:0]   q_cmd;
    logic                q_full;

    obj_cfg_regs u_cfg_regs (
        .clk      (clk),
        .rst      (rst),
        .cpu_cs   (cpu_cs),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_dsn  (cpu_dsn),
        .off_x    (off_x),
        .off_y    (off_y)
    );

    obj_frame_table u_frame_table (
        .clk        (clk),
        .cpu_cs     (cpu_cs),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .cpu_dsn    (cpu_dsn),
        .table_addr (table_addr),
        .table_x    (table_x),
        .table_y    (table_y),
        .table_code (table_code),
        .table_attr (table_attr)
    );

    obj_tile_match u_tile_match (
        .clk        (clk),
        .rst        (rst),
        .match_en   (match_en),
        .vrenderf   (vrenderf),
        .off_y      (off_y),
        .table_y    (table_y),
        .table_code (table_code),
        .table_attr (table_attr),
        .n          (n),
        .inzone     (inzone),
        .vsub       (vsub),
        .code_mn    (code_mn),
        .obj_row    ()             // already folded into code_mn
    );

    obj_line_scan u_line_scan (
        .clk        (clk),
        .rst        (rst),
        .flip       (flip),
        .vrender    (vrender),
        .start      (start),
        .off_x      (off_x),
        .table_x    (table_x),
        .table_y    (table_y),
        .table_attr (table_attr),
        .inzone     (inzone),
        .vsub       (vsub),
        .code_mn    (code_mn),
        .q_full     (q_full),
        .table_addr (table_addr),
        .match_en   (match_en),
        .vrenderf   (vrenderf),
        .n          (n),
        .q_push     (q_push),
        .q_cmd      (q_cmd),
        .line_done  (line_done)
    );

    obj_draw_queue u_draw_queue (
        .clk      (clk),
        .rst      (rst),
        .q_push   (q_push),
        .q_cmd    (q_cmd),
        .dr_ready (dr_ready),
        .q_full   (q_full),
        .dr_valid (dr_valid),
        .dr_cmd   (dr_cmd)
    );

endmodule

/* source/obj_tile_match.sv */
/*
  Vertical zone test and tile code forming for one sprite.
  Fields are sampled only while match_en is high; results hold until the next request.
  code_mn follows n combinationally, so the column loop can step n without a new request.
*/
`timescale 1ns/1ps

module obj_tile_match
    import obj_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              match_en,
    input  logic [VPOS_W-1:0] vrenderf,
    input  logic [VPOS_W-1:0] off_y,
    input  logic [15:0]       table_y,
    input  logic [15:0]       table_code,
    input  logic [15:0]       table_attr,
    input  logic [3:0]        n,          // current tile column
    output logic              inzone,
    output logic [3:0]        vsub,
    output logic [15:0]       code_mn,
    output logic [3:0]        obj_row
);

    logic [VPOS_W-1:0] obj_y;
    logic [VPOS_W-1:0] row;
    logic [3:0]        tile_m;
    logic              vflip;
    logic              zone_hit;
    logic [3:0]        row_idx;
    logic [15:0]       code_q;

    assign tile_m = table_attr[15:12];
    assign vflip  = table_attr[6];

    // line relative to sprite top, wraps at 512
    assign obj_y = table_y[VPOS_W-1:0] - off_y;
    assign row   = vrenderf - obj_y;

    // row < (tile_m+1)*16
    assign zone_hit = !row[8] && (row[7:4] <= tile_m);
    assign row_idx  = vflip ? tile_m - row[7:4] : row[7:4];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            inzone <= 1'b0;
        end else if (match_en) begin
            inzone <= zone_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (match_en) begin
            vsub    <= row[3:0] ^ {4{vflip}};
            obj_row <= row_idx;
            code_q  <= table_code;
        end
    end

    // row steps the middle nibble, column the low one, both wrap
    assign code_mn = {code_q[15:8], code_q[7:4] + obj_row, code_q[3:0] + n};

endmodule

/* verif/obj_scan_tb.sv */
/*
  Table driven testbench for the sprite line scanner.
  Offsets carry over between rows unless a row strobes a lane again.
  Each row writes its sprites from entry 0 and puts an end marker right after them.
*/
`timescale 1ns/1ps

module obj_scan_tb
    import obj_pkg::*;
();

    localparam int NUM_TESTS = 10;
    localparam int MAX_SPR   = 6;

    typedef struct packed {
        logic [15:0]       xoff;
        logic [1:0]        xdsn;   // active low lanes for the x offset write
        logic [15:0]       yoff;
        logic [1:0]        ydsn;
        logic              flip;
        logic [VPOS_W-1:0] vrender;
        logic [7:0]        ready_pct;
    } row_cfg_t;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] code;
        logic [15:0] attr;
    } sprite_t;

    logic              clk;
    logic              rst;
    logic              flip;
    logic [VPOS_W-1:0] vrender;
    logic              start;
    logic              cpu_cs;
    logic [CPU_AW-1:0] cpu_addr;
    logic [15:0]       cpu_dout;
    logic [1:0]        cpu_dsn;
    logic              dr_valid;
    logic [DRAW_W-1:0] dr_cmd;
    logic              dr_ready;
    logic              line_done;

    string             t_name [NUM_TESTS];
    row_cfg_t          row_cfg [NUM_TESTS];
    sprite_t           spr [NUM_TESTS][MAX_SPR];
    int                n_spr [NUM_TESTS];
    int                n_rows;
    logic [XPOS_W-1:0] mdl_xoff;   // offset register model
    logic [VPOS_W-1:0] mdl_yoff;
    logic [DRAW_W-1:0] exp_q [$];
    logic [DRAW_W-1:0] got_q [$];
    int                test_errs;
    int                total_errs;
    int                fail_tests;

    obj_scan_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("watchdog expired after %0d cycles, a line never completed", NUM_TESTS * 2000);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic add_test(input string name, input logic [15:0] xoff, input logic [1:0] xdsn,
                            input logic [15:0] yoff, input logic [1:0] ydsn, input logic fl,
                            input logic [VPOS_W-1:0] vr, input logic [7:0] pct);
        t_name[n_rows]  = name;
        row_cfg[n_rows] = {xoff, xdsn, yoff, ydsn, fl, vr, pct};
        n_spr[n_rows]   = 0;
        n_rows++;
    endtask

    task automatic add_sprite(input logic [15:0] x, input logic [15:0] y,
                              input logic [15:0] code, input logic [15:0] attr);
        spr[n_rows-1][n_spr[n_rows-1]] = {x, y, code, attr};
        n_spr[n_rows-1]++;
    endtask

    task automatic build_table();
        add_test("single_on_line", 16'h0040, 2'b00, 16'h0010, 2'b00, 1'b0, 9'd100, 8'd60);
        add_sprite(16'h2020, 16'd100, 16'h1230, 16'h0003);
        add_test("single_off_line", 16'h0000, 2'b11, 16'h0000, 2'b11, 1'b0, 9'd100, 8'd60);
        add_sprite(16'h2020, 16'd200, 16'h1230, 16'h0003);
        add_test("block_3x2", 16'h0000, 2'b11, 16'h0000, 2'b11, 1'b0, 9'd100, 8'd60);
        add_sprite(16'h4050, 16'd80, 16'h2340, 16'h1205);
        add_test("block_3x2_flipped", 16'h0000, 2'b11, 16'h0000, 2'b11, 1'b0, 9'd100, 8'd60);
        add_sprite(16'h4050, 16'd90, 16'h2340, 16'h1265);   // hflip and vflip
        add_test("end_marker_y", 16'h0000, 2'b11, 16'h0000, 2'b11, 1'b0, 9'd100, 8'd60);
        add_sprite(16'h0030, 16'd100, 16'h0100, 16'h0001);
        add_sprite(16'h0040, 16'h8064, 16'h0200, 16'h0001);
        add_sprite(16'h0050, 16'd100, 16'h0300, 16'h0001);
        add_test("end_marker_attr", 16'h0000, 2'b11, 16'h0000, 2'b11, 1'b0, 9'd100, 8'd60);
        add_sprite(16'h0030, 16'd100, 16'h0400, 16'h0002);
        add_sprite(16'h0060, 16'd100, 16'h0500, 16'hff00);
        add_sprite(16'h0070, 16'd100, 16'h0600, 16'h0002);
        add_test("offset_low_lane", 16'h0145, 2'b10, 16'h0025, 2'b10, 1'b0, 9'd100, 8'd60);
        add_sprite(16'h63f8, 16'd121, 16'h0800, 16'h0207);   // first column wraps off screen
        add_sprite(16'h0010, 16'd121, 16'h0900, 16'h0000);
        add_test("offset_high_lane", 16'h0300, 2'b01, 16'h0100, 2'b01, 1'b0, 9'd100, 8'd60);
        add_sprite(16'h0210, 16'h0179, 16'h0a10, 16'h0104);
        add_sprite(16'h0100, 16'h0179, 16'h0a20, 16'h0000);
        add_test("flip_line", 16'h0040, 2'b00, 16'h0010, 2'b00, 1'b1, 9'h020, 8'd60);
        add_sprite(16'h0020, 16'h0020, 16'h0a00, 16'h0000);
        add_sprite(16'h0040, 16'h00d8, 16'h0b00, 16'h0000);
        add_test("backpressure", 16'h0000, 2'b11, 16'h0000, 2'b11, 1'b0, 9'd50, 8'd15);
        add_sprite(16'h2010, 16'd40, 16'h1000, 16'h1301);
        add_sprite(16'h4060, 16'd45, 16'h2010, 16'h1322);
        add_sprite(16'h60a0, 16'd30, 16'h3020, 16'h1343);
        add_sprite(16'ha100, 16'd50, 16'h4030, 16'h1364);
    endtask

    task automatic cpu_write(input logic [CPU_AW-1:0] addr, input logic [15:0] data,
                             input logic [1:0] dsn);
        @(posedge clk);
        #1;
        cpu_cs   = 1'b1;
        cpu_addr = addr;
        cpu_dout = data;
        cpu_dsn  = dsn;
        @(posedge clk);
        #1;
        cpu_cs  = 1'b0;
        cpu_dsn = 2'b11;
    endtask

    task automatic write_offsets(input int t);
        logic [XPOS_W-1:0] mx;
        logic [VPOS_W-1:0] my;
        cpu_write({1'b1, 7'd0, REG_XOFF}, row_cfg[t].xoff, row_cfg[t].xdsn);
        cpu_write({1'b1, 7'd0, REG_YOFF}, row_cfg[t].yoff, row_cfg[t].ydsn);
        mx = mdl_xoff;
        my = mdl_yoff;
        if (!row_cfg[t].xdsn[0]) mx[7:0] = row_cfg[t].xoff[7:0];
        if (!row_cfg[t].xdsn[1]) mx[9:8] = row_cfg[t].xoff[9:8];
        if (!row_cfg[t].ydsn[0]) my[7:0] = row_cfg[t].yoff[7:0];
        if (!row_cfg[t].ydsn[1]) my[8]   = row_cfg[t].yoff[8];
        mx = mx - XOFF_BIAS;   // bias comes off the merged word
        my = my - YOFF_BIAS;
        if (!row_cfg[t].xdsn[0]) mdl_xoff[7:0] = mx[7:0];
        if (!row_cfg[t].xdsn[1]) mdl_xoff[9:8] = mx[9:8];
        if (!row_cfg[t].ydsn[0]) mdl_yoff[7:0] = my[7:0];
        if (!row_cfg[t].ydsn[1]) mdl_yoff[8]   = my[8];
    endtask

    task automatic write_entry(input logic [7:0] idx, input sprite_t s);
        cpu_write({1'b0, idx, FLD_X}, s.x, 2'b00);
        cpu_write({1'b0, idx, FLD_Y}, s.y, 2'b00);
        cpu_write({1'b0, idx, FLD_CODE}, s.code, 2'b00);
        cpu_write({1'b0, idx, FLD_ATTR}, s.attr, 2'b00);
    endtask

    // reference model of one line from the sprite field rules
    task automatic build_expected(input int t);
        logic [VPOS_W-1:0] vrf;
        logic [VPOS_W-1:0] row;
        logic [3:0]        vsub;
        logic [3:0]        ridx;
        logic [3:0]        n;
        logic [3:0]        npos;
        logic [XPOS_W-1:0] effx;
        sprite_t           s;
        exp_q.delete();
        vrf = row_cfg[t].vrender;
        if (row_cfg[t].flip) vrf[7:0] = ~vrf[7:0];
        for (int i = 0; i < n_spr[t]; i++) begin
            s = spr[t][i];
            if (s.y[15] || s.attr[15:8] == 8'hff) break;
            row = vrf - (s.y[8:0] - mdl_yoff);
            if (int'(row) < (int'(s.attr[15:12]) + 1) * 16) begin
                vsub = s.attr[6] ? ~row[3:0] : row[3:0];
                ridx = s.attr[6] ? s.attr[15:12] - row[7:4] : row[7:4];
                for (int c = 0; c <= int'(s.attr[11:8]); c++) begin
                    n    = 4'(c);
                    npos = s.attr[5] ? s.attr[11:8] - n : n;
                    effx = s.x[9:0] - mdl_xoff + XPOS_W'(int'(npos) * 16);
                    if (!effx[9]) begin
                        exp_q.push_back({s.code[15:8], s.code[7:4] + ridx, s.code[3:0] + n,
                                         4'h0, vsub, s.attr[7:0], effx[8:0], s.x[15:13]});
                    end
                end
            end
        end
    endtask

    task automatic collect_line(input int t);
        logic              seen_done;
        logic              stalled;
        logic [DRAW_W-1:0] held_cmd;
        seen_done = 1'b0;
        stalled   = 1'b0;
        held_cmd  = '0;
        got_q.delete();
        forever begin
            @(posedge clk);
            #1;
            dr_ready = int'($urandom % 100) < int'(row_cfg[t].ready_pct);
            @(negedge clk);   // a transfer happens on the next rising edge
            if (stalled && (!dr_valid || dr_cmd !== held_cmd)) begin
                $display("%s: dr_valid dropped or dr_cmd changed before the transfer", t_name[t]);
                test_errs++;
            end
            if (dr_valid && dr_ready) got_q.push_back(dr_cmd);
            stalled  = dr_valid && !dr_ready;   // command offered but not taken
            held_cmd = dr_cmd;
            if (line_done) seen_done = 1'b1;
            if (seen_done && !dr_valid) break;
        end
        @(posedge clk);
        #1;
        dr_ready = 1'b0;
    endtask

    task automatic check_cmd(input string name, input int idx,
                             input logic [DRAW_W-1:0] exp_cmd, input logic [DRAW_W-1:0] act_cmd);
        if (act_cmd !== exp_cmd) begin
            // fields shown as code/attr/hpos/prio
            $display("[FAIL] %s cmd %0d: expected %h/%h/%h/%h, actual %h/%h/%h/%h", name, idx,
                     exp_cmd[43:28], exp_cmd[27:12], exp_cmd[11:3], exp_cmd[2:0],
                     act_cmd[43:28], act_cmd[27:12], act_cmd[11:3], act_cmd[2:0]);
            test_errs++;
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        if (act_n != exp_n) begin
            $display("[FAIL] %s command count: expected %0d, actual %0d", name, exp_n, act_n);
            test_errs++;
        end
    endtask

    task automatic run_test(input int t);
        int n_chk;
        test_errs = 0;
        write_offsets(t);
        for (int i = 0; i < n_spr[t]; i++) write_entry(8'(i), spr[t][i]);
        write_entry(8'(n_spr[t]), {16'h0000, 16'h8000, 16'h0000, 16'h0000});   // end of list
        build_expected(t);
        @(posedge clk);
        #1;
        flip    = row_cfg[t].flip;
        vrender = row_cfg[t].vrender;
        start   = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        collect_line(t);
        check_count(t_name[t], exp_q.size(), got_q.size());
        n_chk = (exp_q.size() < got_q.size()) ? exp_q.size() : got_q.size();
        for (int i = 0; i < n_chk; i++) check_cmd(t_name[t], i, exp_q[i], got_q[i]);
        $display("test %-18s %0d commands, %0d errors", t_name[t], got_q.size(), test_errs);
        if (test_errs != 0) fail_tests++;
        total_errs += test_errs;
    endtask

    initial begin
        void'($urandom(17153));
        rst        = 1'b1;
        flip       = 1'b0;
        vrender    = '0;
        start      = 1'b0;
        cpu_cs     = 1'b0;
        cpu_addr   = '0;
        cpu_dout   = '0;
        cpu_dsn    = 2'b11;
        dr_ready   = 1'b0;
        mdl_xoff   = '0;
        mdl_yoff   = '0;
        n_rows     = 0;
        total_errs = 0;
        fail_tests = 0;
        build_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int t = 0; t < n_rows; t++) run_test(t);
        $display("tests %0d, failed %0d, errors %0d", n_rows, fail_tests, total_errs);
        if (total_errs == 0 && n_rows == NUM_TESTS) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
